// File: src.f
source/svc_pkg.sv
source/svc_cmd_queue.sv
source/svc_cmd_decode.sv
source/domain_reset_gen.sv
source/lcc_clk_sel.sv
source/otp_fault_inject.sv
source/fc_lcc_svc_top.sv
bench/svc_checker.sv
bench/tb_fc_lcc_svc.sv

// File: bench/tb_fc_lcc_svc.sv
`timescale 1ns/1ps

module tb_fc_lcc_svc;

  localparam int CLK_PERIOD = 100;
  localparam int N_STATUS   = 40;
  localparam int N_BURST    = 60;
  localparam int N_CLK      = 6;
  // The reset and fault tests send seven directed commands.
  localparam int NUM_CMDS   = N_STATUS + N_BURST + N_CLK + 7;

  logic                       clk = 1'b0;
  logic                       cptra_rst_b;
  logic                       cmd_valid_i;
  logic [svc_pkg::CMD_W-1:0]  cmd_i;
  logic                       credit_o;
  logic                       zeroizing_i;
  logic                       clk_byp_ack_i;
  svc_pkg::otp_wr_t           otp_wr_i;
  logic [svc_pkg::OTP_AW-1:0] otp_rd_addr_i;
  logic [svc_pkg::OTP_DW-1:0] otp_rd_data_o;
  svc_pkg::svc_status_t       status_o;
  logic                       domain_rst_b_o;
  svc_pkg::clk_freq_e         clk_sel_o;
  logic                       ext_clk_req_o;
  logic                       clk_switch_o;

  int                         seed = 88;
  int                         credits;
  int                         accepted;
  logic [7:0]                 codes [17];
  svc_pkg::svc_status_t       exp_status;
  svc_pkg::clk_freq_e         exp_sel;
  logic                       exp_req;
  logic                       fault_seen;
  logic [15:0]                mem_model [32];
  logic [15:0]                fault_model [7];

  always #(CLK_PERIOD / 2) clk = ~clk;

  fc_lcc_svc_top DUT (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (cmd_i),
    .credit_o       (credit_o),
    .zeroizing_i    (zeroizing_i),
    .clk_byp_ack_i  (clk_byp_ack_i),
    .otp_wr_i       (otp_wr_i),
    .otp_rd_addr_i  (otp_rd_addr_i),
    .otp_rd_data_o  (otp_rd_data_o),
    .status_o       (status_o),
    .domain_rst_b_o (domain_rst_b_o),
    .clk_sel_o      (clk_sel_o),
    .ext_clk_req_o  (ext_clk_req_o),
    .clk_switch_o   (clk_switch_o)
  );

  svc_checker chk (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .cmd_valid_i    (cmd_valid_i),
    .credit_i       (credit_o),
    .status_i       (status_o),
    .domain_rst_b_i (domain_rst_b_o),
    .clk_sel_i      (clk_sel_o),
    .ext_clk_req_i  (ext_clk_req_o),
    .clk_switch_i   (clk_switch_o),
    .clk_byp_ack_i  (clk_byp_ack_i),
    .otp_rd_data_i  (otp_rd_data_o)
  );

  // The source regains one credit for every credit pulse.
  always @(negedge clk) begin
    if (cptra_rst_b && credit_o) begin
      credits++;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  task automatic snapshot_faults(logic corr);
    logic [15:0] data;
    logic        locked;
    if (!fault_seen) begin
      fault_seen = 1'b1;
      for (int p = 0; p < 7; p++) begin
        data   = mem_model[4 * p];
        locked = (mem_model[4 * p + 3] != 16'h0);
        if (corr) begin
          fault_model[p] = data ^ {15'h0, locked};
        end else begin
          fault_model[p] = locked ? ~data : data;
        end
      end
    end
  endtask

  task automatic model_cmd(logic [7:0] code);
    case (code)
      svc_pkg::CMD_FC_FORCE_ZEROIZATION:       exp_status.fips_zeroize = 1'b1;
      svc_pkg::CMD_RELEASE_ZEROIZATION:        exp_status.fips_zeroize = 1'b0;
      svc_pkg::CMD_LC_TRIGGER_ESCALATION0:     exp_status.esc_scrap0   = 1'b1;
      svc_pkg::CMD_LC_TRIGGER_ESCALATION0_DIS: exp_status.esc_scrap0   = 1'b0;
      svc_pkg::CMD_LC_TRIGGER_ESCALATION1:     exp_status.esc_scrap1   = 1'b1;
      svc_pkg::CMD_LC_TRIGGER_ESCALATION1_DIS: exp_status.esc_scrap1   = 1'b0;
      svc_pkg::CMD_LC_DISABLE_SVA:             exp_status.sva_disable  = 1'b1;
      svc_pkg::CMD_LC_ENABLE_SVA:              exp_status.sva_disable  = 1'b0;
      svc_pkg::CMD_FC_LCC_EXT_CLK_160MHZ:      exp_sel = svc_pkg::CLK_160MHZ;
      svc_pkg::CMD_FC_LCC_EXT_CLK_400MHZ:      exp_sel = svc_pkg::CLK_400MHZ;
      svc_pkg::CMD_FC_LCC_EXT_CLK_500MHZ:      exp_sel = svc_pkg::CLK_500MHZ;
      svc_pkg::CMD_FC_LCC_EXT_CLK_1000MHZ:     exp_sel = svc_pkg::CLK_1000MHZ;
      svc_pkg::CMD_FC_LCC_CORRECTABLE_FAULT:   snapshot_faults(1'b1);
      svc_pkg::CMD_FC_LCC_UNCORRECTABLE_FAULT: snapshot_faults(1'b0);
      default: ;
    endcase
    if (code >= svc_pkg::CMD_FC_LCC_EXT_CLK_160MHZ &&
        code <= svc_pkg::CMD_FC_LCC_EXT_CLK_1000MHZ) begin
      exp_req = 1'b1;
    end
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  task automatic tick(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Roughly one code in seven is outside the command set.
  function automatic logic [7:0] pick_code();
    int r;
    r = $urandom_range(0, 19);
    if (r < 17) begin
      return codes[r];
    end
    return 8'h17 + 8'($urandom_range(0, 232));
  endfunction

  task automatic send_cmd(logic [7:0] code);
    int n;
    n = 0;
    while (credits == 0 && n < 50) begin
      tick(1);
      n++;
    end
    if (credits == 0) begin
      chk.fail("no credit came back to the command source");
    end else begin
      cmd_valid_i = 1'b1;
      cmd_i       = code;
      credits--;
      accepted++;
      model_cmd(code);
      tick(1);
      cmd_valid_i = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (credits != svc_pkg::QUEUE_DEPTH && n < 40) begin
      tick(1);
      n++;
    end
    if (credits != svc_pkg::QUEUE_DEPTH) begin
      chk.fail("credits did not all return");
    end
  endtask

  task automatic wait_rst(logic level);
    int n;
    n = 0;
    while (domain_rst_b_o !== level && n < 40) begin
      tick(1);
      n++;
    end
    if (domain_rst_b_o !== level) begin
      chk.fail("domain reset did not reach the awaited level");
    end
  endtask

  task automatic wait_pulse();
    int p0;
    int n;
    p0 = chk.pulse_count;
    n  = 0;
    while (chk.pulse_count == p0 && n < 40) begin
      tick(1);
      n++;
    end
    if (chk.pulse_count == p0) begin
      chk.fail("domain reset pulse never ended");
    end
  endtask

  task automatic otp_write(logic [4:0] a, logic [15:0] d);
    otp_wr_i.valid = 1'b1;
    otp_wr_i.addr  = a;
    otp_wr_i.data  = d;
    mem_model[a]   = d;
    tick(1);
    otp_wr_i.valid = 1'b0;
  endtask

  task automatic otp_check(logic [4:0] a);
    otp_rd_addr_i = a;
    tick(1);
    if (fault_seen && a[1:0] == 2'd0 && a < 5'd28) begin
      chk.check_rd(a, fault_model[a / 4]);
    end else begin
      chk.check_rd(a, mem_model[a]);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    void'($urandom(seed));
    codes = '{svc_pkg::CMD_FC_FORCE_ZEROIZATION, svc_pkg::CMD_RELEASE_ZEROIZATION,
              svc_pkg::CMD_LC_TRIGGER_ESCALATION0, svc_pkg::CMD_LC_TRIGGER_ESCALATION0_DIS,
              svc_pkg::CMD_LC_TRIGGER_ESCALATION1, svc_pkg::CMD_LC_TRIGGER_ESCALATION1_DIS,
              svc_pkg::CMD_FC_LCC_EXT_CLK_160MHZ, svc_pkg::CMD_FC_LCC_EXT_CLK_400MHZ,
              svc_pkg::CMD_FC_LCC_EXT_CLK_500MHZ, svc_pkg::CMD_FC_LCC_EXT_CLK_1000MHZ,
              svc_pkg::CMD_FC_LCC_RESET, svc_pkg::CMD_FC_LCC_EN_RESET_WHILE_0ING,
              svc_pkg::CMD_FC_LCC_DIS_RESET_WHILE_0ING, svc_pkg::CMD_LC_DISABLE_SVA,
              svc_pkg::CMD_LC_ENABLE_SVA, svc_pkg::CMD_FC_LCC_CORRECTABLE_FAULT,
              svc_pkg::CMD_FC_LCC_UNCORRECTABLE_FAULT};
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    zeroizing_i   = 1'b0;
    clk_byp_ack_i = 1'b0;
    otp_wr_i      = '0;
    otp_rd_addr_i = '0;
    credits       = svc_pkg::QUEUE_DEPTH;
    accepted      = 0;
    exp_status    = '0;
    exp_sel       = svc_pkg::CLK_1000MHZ;
    exp_req       = 1'b0;
    fault_seen    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    cptra_rst_b = 1'b1;

    chk.begin_test("reset_values");
    chk.check_status(exp_status);
    chk.check_clk(exp_sel, 1'b0, 1'b0);
    chk.end_test();

    // Digest words are either zero or forced nonzero, so each partition is
    // randomly locked or open.
    chk.begin_test("otp_program");
    for (int a = 0; a < 32; a++) begin
      if (a % 4 == 3 && a < 28) begin
        otp_write(5'(a), $urandom_range(0, 1) ? (16'($urandom) | 16'h1) : 16'h0);
      end else begin
        otp_write(5'(a), 16'($urandom));
      end
    end
    for (int a = 0; a < 32; a++) begin
      otp_check(5'(a));
    end
    chk.end_test();

    chk.begin_test("status_flags");
    repeat (N_STATUS) begin
      send_cmd(pick_code());
      wait_idle();
      chk.check_status(exp_status);
    end
    chk.end_test();

    chk.begin_test("credit_burst");
    repeat (N_BURST) begin
      send_cmd(pick_code());
    end
    wait_idle();
    chk.check_status(exp_status);
    chk.check_credits(accepted);
    tick(1);
    chk.check_clk(exp_sel, exp_req, 1'b0);
    chk.end_test();

    chk.begin_test("domain_reset");
    wait_rst(1'b1);
    send_cmd(svc_pkg::CMD_FC_LCC_RESET);
    wait_pulse();
    chk.check_pulse(11);
    send_cmd(svc_pkg::CMD_FC_LCC_RESET);
    wait_rst(1'b0);
    send_cmd(svc_pkg::CMD_FC_LCC_RESET);
    wait_pulse();
    chk.check_pulse(11);
    send_cmd(svc_pkg::CMD_FC_LCC_EN_RESET_WHILE_0ING);
    wait_idle();
    tick(2);
    zeroizing_i = 1'b1;
    wait_rst(1'b0);
    zeroizing_i = 1'b0;
    wait_pulse();
    chk.check_pulse(11);
    send_cmd(svc_pkg::CMD_FC_LCC_DIS_RESET_WHILE_0ING);
    wait_idle();
    chk.end_test();

    chk.begin_test("clock_select");
    repeat (N_CLK) begin
      send_cmd(codes[6 + $urandom_range(0, 3)]);
      wait_idle();
      tick(1);
      chk.check_clk(exp_sel, 1'b1, 1'b0);
      tick($urandom_range(0, 3));
      chk.check_clk(exp_sel, 1'b1, 1'b0);
      clk_byp_ack_i = 1'b1;
      @(negedge clk);
      chk.check_clk(exp_sel, 1'b1, 1'b1);
      tick(1);
      clk_byp_ack_i = 1'b0;
      exp_req       = 1'b0;
      chk.check_clk(exp_sel, 1'b0, 1'b0);
    end
    chk.end_test();

    chk.begin_test("fault_inject");
    send_cmd(svc_pkg::CMD_FC_LCC_CORRECTABLE_FAULT);
    send_cmd(svc_pkg::CMD_FC_LCC_UNCORRECTABLE_FAULT);
    wait_idle();
    tick(1);
    for (int p = 0; p < 7; p++) begin
      otp_check(5'(4 * p));
    end
    chk.end_test();

    chk.begin_test("otp_reads");
    repeat (8) begin
      otp_write(5'($urandom_range(0, 31)), 16'($urandom));
    end
    for (int a = 0; a < 32; a++) begin
      otp_check(5'(a));
    end
    chk.end_test();

    chk.report();
    if (chk.err_total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Every command gets a generous 20 cycles, plus room for the OTP passes.
  initial begin
    #(CLK_PERIOD * (NUM_CMDS * 20 + 500));
    $display("watchdog: the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: bench/svc_checker.sv
`timescale 1ns/1ps

module svc_checker (
  input  logic                       clk,
  input  logic                       cptra_rst_b,
  input  logic                       cmd_valid_i,
  input  logic                       credit_i,
  input  svc_pkg::svc_status_t       status_i,
  input  logic                       domain_rst_b_i,
  input  logic [9:0]                 clk_sel_i,
  input  logic                       ext_clk_req_i,
  input  logic                       clk_switch_i,
  input  logic                       clk_byp_ack_i,
  input  logic [svc_pkg::OTP_DW-1:0] otp_rd_data_i
);

  string cur_test = "reset";
  int    test_errs = 0;
  int    err_total = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    credit_count = 0;
  int    outstanding = 0;
  int    low_len = 0;
  int    last_len = 0;
  int    pulse_count = 0;

  task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected 'h%0h, actual 'h%0h", cur_test, what, exp, act);
      test_errs++;
      err_total++;
    end
  endtask

  task automatic fail(string msg);
    $display("test %s: %s", cur_test, msg);
    test_errs++;
    err_total++;
  endtask

  task automatic begin_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %-14s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "failed",
             test_errs);
  endtask

  task automatic report();
    $display("totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
  endtask

  // ----------------------------------------
  // Port checks called by the bench
  // ----------------------------------------

  task automatic check_status(svc_pkg::svc_status_t exp);
    compare("status", exp, status_i);
  endtask

  task automatic check_clk(logic [9:0] sel, logic req, logic sw);
    compare("clk_sel", sel, clk_sel_i);
    compare("ext_clk_req", req, ext_clk_req_i);
    compare("clk_switch", sw, clk_switch_i);
  endtask

  task automatic check_rd(logic [svc_pkg::OTP_AW-1:0] addr, logic [svc_pkg::OTP_DW-1:0] exp);
    compare($sformatf("otp[%0d]", addr), exp, otp_rd_data_i);
  endtask

  task automatic check_pulse(int exp);
    compare("reset_low_cycles", exp, last_len);
  endtask

  task automatic check_credits(int exp);
    compare("credit_pulses", exp, credit_count);
  endtask

  // ----------------------------------------
  // Monitors, sampled in the middle of the cycle
  // ----------------------------------------

  always @(negedge clk) begin
    if (cptra_rst_b) begin
      if (cmd_valid_i) begin
        outstanding++;
      end
      if (credit_i) begin
        credit_count++;
        outstanding--;
      end
      if (outstanding < 0) begin
        fail("credit_o pulsed with no command outstanding");
      end
      // A finished low phase closes one domain reset pulse.
      if (!domain_rst_b_i) begin
        low_len++;
      end else if (low_len != 0) begin
        last_len = low_len;
        pulse_count++;
        low_len = 0;
      end
      // Without the bypass acknowledge no switch can happen.
      if (!clk_byp_ack_i) begin
        compare("clk_switch", 1'b0, clk_switch_i);
      end
    end
  end

endmodule

// File: source/fc_lcc_svc_top.sv
`timescale 1ns/1ps

module fc_lcc_svc_top (
  input  logic                       clk,
  input  logic                       cptra_rst_b,

  // Service command input with credit return.
  input  logic                       cmd_valid_i,
  input  logic [svc_pkg::CMD_W-1:0]  cmd_i,
  output logic                       credit_o,

  input  logic                       zeroizing_i,
  input  logic                       clk_byp_ack_i,

  // OTP shadow memory access.
  input  svc_pkg::otp_wr_t           otp_wr_i,
  input  logic [svc_pkg::OTP_AW-1:0] otp_rd_addr_i,
  output logic [svc_pkg::OTP_DW-1:0] otp_rd_data_o,

  output svc_pkg::svc_status_t       status_o,
  output logic                       domain_rst_b_o,
  output svc_pkg::clk_freq_e         clk_sel_o,
  output logic                       ext_clk_req_o,
  output logic                       clk_switch_o
);

  logic [svc_pkg::CMD_W-1:0] head;
  logic                      not_empty;
  logic                      pop;
  svc_pkg::svc_action_t      action;

  // ----------------------------------------
  // Command path
  // ----------------------------------------

  svc_cmd_queue u_cmd_queue (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (not_empty),
    .credit_o    (credit_o)
  );

  svc_cmd_decode u_cmd_decode (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .head_i      (head),
    .not_empty_i (not_empty),
    .pop_o       (pop),
    .status_o    (status_o),
    .action_o    (action)
  );

  // ----------------------------------------
  // Effect blocks
  // ----------------------------------------

  domain_reset_gen u_domain_reset_gen (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .action_i       (action),
    .zeroizing_i    (zeroizing_i),
    .domain_rst_b_o (domain_rst_b_o)
  );

  lcc_clk_sel u_lcc_clk_sel (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .action_i      (action),
    .clk_byp_ack_i (clk_byp_ack_i),
    .clk_sel_o     (clk_sel_o),
    .ext_clk_req_o (ext_clk_req_o),
    .clk_switch_o  (clk_switch_o)
  );

  otp_fault_inject u_otp_fault_inject (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .action_i      (action),
    .otp_wr_i      (otp_wr_i),
    .otp_rd_addr_i (otp_rd_addr_i),
    .otp_rd_data_o (otp_rd_data_o)
  );

endmodule

// File: source/otp_fault_inject.sv
`timescale 1ns/1ps

module otp_fault_inject (
  input  logic                       clk,
  input  logic                       cptra_rst_b,
  input  svc_pkg::svc_action_t       action_i,
  input  svc_pkg::otp_wr_t           otp_wr_i,
  input  logic [svc_pkg::OTP_AW-1:0] otp_rd_addr_i,
  output logic [svc_pkg::OTP_DW-1:0] otp_rd_data_o
);

  logic [svc_pkg::OTP_DW-1:0]   mem_q        [svc_pkg::OTP_WORDS];
  logic [svc_pkg::OTP_DW-1:0]   fault_word_q [svc_pkg::NUM_PART];
  logic [svc_pkg::NUM_PART-1:0] part_locked;
  logic                         fault_active_q;
  logic                         capture;
  logic [svc_pkg::OTP_DW-1:0]   rd_word;
  logic [svc_pkg::OTP_DW-1:0]   rd_data_q;

  // Only the first fault command takes a snapshot.
  assign capture = (action_i.fault_corr | action_i.fault_uncorr) & ~fault_active_q;

  // ----------------------------------------
  // Shadow memory
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (otp_wr_i.valid) begin
      mem_q[otp_wr_i.addr] <= otp_wr_i.data;
    end
  end

  // ----------------------------------------
  // Per-partition fault capture
  // ----------------------------------------

  for (genvar p = 0; p < svc_pkg::NUM_PART; p++) begin : g_part
    // A partition counts as locked once its digest word is nonzero.
    assign part_locked[p] = |mem_q[svc_pkg::PART_DIGEST_ADDR[p]];

    always_ff @(posedge clk) begin
      if (capture) begin
        if (action_i.fault_corr) begin
          fault_word_q[p] <= mem_q[svc_pkg::PART_DATA_ADDR[p]] ^
                             {{(svc_pkg::OTP_DW - 1){1'b0}}, part_locked[p]};
        end else begin
          fault_word_q[p] <= mem_q[svc_pkg::PART_DATA_ADDR[p]] ^
                             {svc_pkg::OTP_DW{part_locked[p]}};
        end
      end
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
    end else if (capture) begin
      fault_active_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Read path with fault overlay
  // ----------------------------------------

  always_comb begin
    rd_word = mem_q[otp_rd_addr_i];
    if (fault_active_q) begin
      for (int p = 0; p < svc_pkg::NUM_PART; p++) begin
        if (otp_rd_addr_i == svc_pkg::PART_DATA_ADDR[p]) begin
          rd_word = fault_word_q[p];
        end
      end
    end
  end

  // Reads see the memory contents from before a write in the same cycle.
  always_ff @(posedge clk) begin
    rd_data_q <= rd_word;
  end

  assign otp_rd_data_o = rd_data_q;

endmodule

// File: source/lcc_clk_sel.sv
`timescale 1ns/1ps

module lcc_clk_sel (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  svc_pkg::svc_action_t action_i,
  input  logic                 clk_byp_ack_i,
  output svc_pkg::clk_freq_e   clk_sel_o,
  output logic                 ext_clk_req_o,
  output logic                 clk_switch_o
);

  svc_pkg::clk_freq_e clk_sel_q;
  logic               req_q;

  // The switch happens in the cycle where a pending request meets the bypass ack.
  assign clk_switch_o = req_q & clk_byp_ack_i;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q <= svc_pkg::CLK_1000MHZ;
      req_q     <= 1'b0;
    end else begin
      if (clk_switch_o) begin
        req_q <= 1'b0;
      end
      // A fresh selection in the same cycle as a switch opens a new request.
      if (action_i.clk_req) begin
        clk_sel_q <= action_i.clk_freq;
        req_q     <= 1'b1;
      end
    end
  end

  assign clk_sel_o     = clk_sel_q;
  assign ext_clk_req_o = req_q;

endmodule

// File: source/domain_reset_gen.sv
`timescale 1ns/1ps

module domain_reset_gen (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  svc_pkg::svc_action_t action_i,
  input  logic                 zeroizing_i,
  output logic                 domain_rst_b_o
);

  logic                          rst0ing_en_q;
  logic                          active_q;
  logic [svc_pkg::RST_CNT_W-1:0] cnt_q;
  logic                          start;

  // A new pulse may only begin once the previous one has finished.
  assign start = ~active_q &
                 (action_i.rst_req | (rst0ing_en_q & zeroizing_i));

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst0ing_en_q <= 1'b0;
      active_q     <= 1'b0;
      cnt_q        <= '0;
    end else begin
      if (action_i.rst0ing_en) begin
        rst0ing_en_q <= 1'b1;
      end else if (action_i.rst0ing_dis) begin
        rst0ing_en_q <= 1'b0;
      end

      if (start) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        // The last count value still holds the domain in reset.
        if (cnt_q == (svc_pkg::RST_CNT_W)'(svc_pkg::RST_CYCLES)) begin
          active_q <= 1'b0;
          cnt_q    <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign domain_rst_b_o = ~active_q;

endmodule

// File: source/svc_cmd_decode.sv
`timescale 1ns/1ps

module svc_cmd_decode (
  input  logic                      clk,
  input  logic                      cptra_rst_b,
  input  logic [svc_pkg::CMD_W-1:0] head_i,
  input  logic                      not_empty_i,
  output logic                      pop_o,
  output svc_pkg::svc_status_t      status_o,
  output svc_pkg::svc_action_t      action_o
);

  logic [svc_pkg::CMD_W-1:0] cmd_q;
  logic                      cmd_vld_q;
  svc_pkg::svc_status_t      status_d;
  svc_pkg::svc_status_t      status_q;
  svc_pkg::svc_action_t      action_d;
  svc_pkg::svc_action_t      action_q;

  // The queue head is taken whenever one is there.
  assign pop_o = not_empty_i;

  // ----------------------------------------
  // Stage 1: capture the popped command
  // ----------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd_vld_q <= 1'b0;
    end else begin
      cmd_vld_q <= not_empty_i;
    end
  end

  always_ff @(posedge clk) begin
    if (not_empty_i) begin
      cmd_q <= head_i;
    end
  end

  // ----------------------------------------
  // Stage 2: decode into flags and strobes
  // ----------------------------------------

  always_comb begin
    status_d = status_q;
    action_d = '0;
    action_d.clk_freq = svc_pkg::CLK_1000MHZ;
    if (cmd_vld_q) begin
      case (cmd_q)
        svc_pkg::CMD_FC_FORCE_ZEROIZATION:        status_d.fips_zeroize = 1'b1;
        svc_pkg::CMD_RELEASE_ZEROIZATION:         status_d.fips_zeroize = 1'b0;
        svc_pkg::CMD_LC_TRIGGER_ESCALATION0:      status_d.esc_scrap0   = 1'b1;
        svc_pkg::CMD_LC_TRIGGER_ESCALATION0_DIS:  status_d.esc_scrap0   = 1'b0;
        svc_pkg::CMD_LC_TRIGGER_ESCALATION1:      status_d.esc_scrap1   = 1'b1;
        svc_pkg::CMD_LC_TRIGGER_ESCALATION1_DIS:  status_d.esc_scrap1   = 1'b0;
        svc_pkg::CMD_LC_DISABLE_SVA:              status_d.sva_disable  = 1'b1;
        svc_pkg::CMD_LC_ENABLE_SVA:               status_d.sva_disable  = 1'b0;
        svc_pkg::CMD_FC_LCC_RESET:                action_d.rst_req      = 1'b1;
        svc_pkg::CMD_FC_LCC_EN_RESET_WHILE_0ING:  action_d.rst0ing_en   = 1'b1;
        svc_pkg::CMD_FC_LCC_DIS_RESET_WHILE_0ING: action_d.rst0ing_dis  = 1'b1;
        svc_pkg::CMD_FC_LCC_CORRECTABLE_FAULT:    action_d.fault_corr   = 1'b1;
        svc_pkg::CMD_FC_LCC_UNCORRECTABLE_FAULT:  action_d.fault_uncorr = 1'b1;
        svc_pkg::CMD_FC_LCC_EXT_CLK_160MHZ: begin
          action_d.clk_req  = 1'b1;
          action_d.clk_freq = svc_pkg::CLK_160MHZ;
        end
        svc_pkg::CMD_FC_LCC_EXT_CLK_400MHZ: begin
          action_d.clk_req  = 1'b1;
          action_d.clk_freq = svc_pkg::CLK_400MHZ;
        end
        svc_pkg::CMD_FC_LCC_EXT_CLK_500MHZ: begin
          action_d.clk_req  = 1'b1;
          action_d.clk_freq = svc_pkg::CLK_500MHZ;
        end
        svc_pkg::CMD_FC_LCC_EXT_CLK_1000MHZ: begin
          action_d.clk_req  = 1'b1;
          action_d.clk_freq = svc_pkg::CLK_1000MHZ;
        end
        // Unknown codes just consume their slot.
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      status_q          <= '0;
      action_q          <= '0;
      action_q.clk_freq <= svc_pkg::CLK_1000MHZ;
    end else begin
      status_q <= status_d;
      action_q <= action_d;
    end
  end

  assign status_o = status_q;
  assign action_o = action_q;

endmodule

// File: source/svc_cmd_queue.sv
`timescale 1ns/1ps

module svc_cmd_queue (
  input  logic                      clk,
  input  logic                      cptra_rst_b,
  input  logic                      cmd_valid_i,
  input  logic [svc_pkg::CMD_W-1:0] cmd_i,
  input  logic                      pop_i,
  output logic [svc_pkg::CMD_W-1:0] head_o,
  output logic                      not_empty_o,
  output logic                      credit_o
);

  logic [svc_pkg::CMD_W-1:0]    slot_q [svc_pkg::QUEUE_DEPTH];
  logic [svc_pkg::QUEUE_AW-1:0] wr_ptr_q;
  logic [svc_pkg::QUEUE_AW-1:0] rd_ptr_q;
  logic [svc_pkg::QUEUE_AW:0]   count_q;
  logic                         full;
  logic                         push;
  logic                         pop;
  logic                         credit_q;

  assign full        = (count_q == (svc_pkg::QUEUE_AW + 1)'(svc_pkg::QUEUE_DEPTH));
  assign not_empty_o = (count_q != '0);

  // The source only sends while it holds a credit, so a push into a full
  // queue is a protocol error and gets dropped here.
  assign push = cmd_valid_i & ~full;
  assign pop  = pop_i & not_empty_o;

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Each freed slot goes back to the source one cycle after the pop.
      credit_q <= pop;
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      slot_q[wr_ptr_q] <= cmd_i;
    end
  end

  assign head_o   = slot_q[rd_ptr_q];
  assign credit_o = credit_q;

endmodule

// File: source/svc_pkg.sv
package svc_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  localparam int CMD_W       = 8;
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);
  localparam int OTP_WORDS   = 32;
  localparam int OTP_AW      = 5;
  localparam int OTP_DW      = 16;
  localparam int NUM_PART    = 7;

  // The reset counter runs from 0 up to RST_CYCLES, so the pulse is RST_CYCLES + 1 long.
  localparam int RST_CYCLES  = 10;
  localparam int RST_CNT_W   = $clog2(RST_CYCLES + 1);

  // ----------------------------------------
  // Secret partition table
  // ----------------------------------------

  // Each partition owns one data word, and its digest sits three words above it.
  localparam logic [OTP_AW-1:0] PART_DATA_ADDR [NUM_PART] = '{
    5'd0, 5'd4, 5'd8, 5'd12, 5'd16, 5'd20, 5'd24
  };
  localparam logic [OTP_AW-1:0] PART_DIGEST_ADDR [NUM_PART] = '{
    5'd3, 5'd7, 5'd11, 5'd15, 5'd19, 5'd23, 5'd27
  };

  // ----------------------------------------
  // Service command codes
  // ----------------------------------------

  localparam logic [CMD_W-1:0] CMD_FC_FORCE_ZEROIZATION        = 8'h01;
  localparam logic [CMD_W-1:0] CMD_RELEASE_ZEROIZATION         = 8'h02;
  localparam logic [CMD_W-1:0] CMD_LC_TRIGGER_ESCALATION0      = 8'h03;
  localparam logic [CMD_W-1:0] CMD_LC_TRIGGER_ESCALATION0_DIS  = 8'h04;
  localparam logic [CMD_W-1:0] CMD_LC_TRIGGER_ESCALATION1      = 8'h05;
  localparam logic [CMD_W-1:0] CMD_LC_TRIGGER_ESCALATION1_DIS  = 8'h06;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_EXT_CLK_160MHZ       = 8'h07;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_EXT_CLK_400MHZ       = 8'h08;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_EXT_CLK_500MHZ       = 8'h09;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_EXT_CLK_1000MHZ      = 8'h0A;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_RESET                = 8'h10;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_EN_RESET_WHILE_0ING  = 8'h11;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_DIS_RESET_WHILE_0ING = 8'h12;
  localparam logic [CMD_W-1:0] CMD_LC_DISABLE_SVA              = 8'h13;
  localparam logic [CMD_W-1:0] CMD_LC_ENABLE_SVA               = 8'h14;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_CORRECTABLE_FAULT    = 8'h15;
  localparam logic [CMD_W-1:0] CMD_FC_LCC_UNCORRECTABLE_FAULT  = 8'h16;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // The encoding is the frequency in MHz.
  typedef enum logic [9:0] {
    CLK_160MHZ  = 10'd160,
    CLK_400MHZ  = 10'd400,
    CLK_500MHZ  = 10'd500,
    CLK_1000MHZ = 10'd1000
  } clk_freq_e;

  typedef struct packed {
    logic fips_zeroize;
    logic esc_scrap0;
    logic esc_scrap1;
    logic sva_disable;
  } svc_status_t;

  typedef struct packed {
    logic      rst_req;
    logic      rst0ing_en;
    logic      rst0ing_dis;
    logic      clk_req;
    clk_freq_e clk_freq;
    logic      fault_corr;
    logic      fault_uncorr;
  } svc_action_t;

  typedef struct packed {
    logic              valid;
    logic [OTP_AW-1:0] addr;
    logic [OTP_DW-1:0] data;
  } otp_wr_t;

endpackage
